// ==== files.f ====
design/store_issue_pkg.sv
design/store_overlap_check.sv
design/byte_enable_gen.sv
design/store_data_align.sv
design/store_lane.sv
design/store_issue_ctrl.sv
design/store_issue_top.sv
bench/store_issue_tb.sv

// ==== bench/store_issue_tb.sv ====
// directed and random tests of the store issue path against a reference model
`timescale 1ns/1ps

module store_issue_tb;
  import store_issue_pkg::*;

  // up to 5 cycles per random pair plus 1000 for the directed tests
  localparam int random_iters = 200;
  localparam int max_cycles = random_iters * 5 + 1000;

  logic       clk;
  logic       rst;
  logic       bus_hold;
  logic       miss_hold;
  logic       miss_pause;
  logic       insert_data;
  logic       req0_en;
  line_addr_t req0_line;
  offset_t    req0_offset;
  size_t      req0_size;
  data_t      req0_data;
  logic       req1_en;
  line_addr_t req1_line;
  offset_t    req1_offset;
  size_t      req1_size;
  data_t      req1_data;
  logic       busy;
  logic       st0_en;
  line_addr_t st0_line;
  bank_t      st0_bank_begin;
  bank_t      st0_bank_end;
  ben_t       st0_ben_begin;
  ben_t       st0_ben_end;
  data_t      st0_data;
  logic       st1_en;
  line_addr_t st1_line;
  bank_t      st1_bank_begin;
  bank_t      st1_bank_end;
  ben_t       st1_ben_begin;
  ben_t       st1_ben_end;
  data_t      st1_data;

  integer seed;
  int     cycle_count;
  int     checks;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;

  store_issue_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("Test failures found");
    $finish;
  end

  // reference model of banks, byte enables and data rotation
  function automatic ben_t model_ben_begin(input int off, input int size);
    int   first;
    int   last;
    ben_t m;
    first = off;
    last = off + (1 << size) - 1;
    m = '0;
    for (int b = first % 4; b < 4; b++) begin
      if ((first / 4 != last / 4) || (b <= last % 4))
        m[b] = 1'b1;
    end
    return m;
  endfunction

  function automatic ben_t model_ben_end(input int off, input int size);
    int   last;
    ben_t m;
    last = off + (1 << size) - 1;
    m = '0;
    if (off / 4 == last / 4)
      return model_ben_begin(off, size);
    for (int b = 0; b <= last % 4; b++)
      m[b] = 1'b1;
    return m;
  endfunction

  function automatic data_t model_rotate(input data_t d, input int off);
    data_t r;
    r = '0;
    for (int i = 0; i < 16; i++)
      r[((i + off) % 16) * 8 +: 8] = d[i * 8 +: 8];
    return r;
  endfunction

  // two byte ranges overlap when each starts no later than the other ends
  function automatic logic model_conflict(input line_addr_t l0, input int off0, input int size0,
                                          input line_addr_t l1, input int off1, input int size1);
    int last0;
    int last1;
    last0 = off0 + (1 << size0) - 1;
    last1 = off1 + (1 << size1) - 1;
    return (l0 == l1) && (off0 <= last1) && (off1 <= last0);
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [127:0] expected, input logic [127:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Fail %s: %s expected %0h actual %0h", test, field, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string test);
    tests_run++;
    if (test_errors > 0)
      tests_failed++;
    $display("%s finished with %0d errors", test, test_errors);
    test_errors = 0;
  endtask

  task automatic check_strobes(input string test, input logic e0, input logic e1,
                               input logic b);
    check_value(test, "st0_en", e0, st0_en);
    check_value(test, "st1_en", e1, st1_en);
    check_value(test, "busy", b, busy);
  endtask

  task automatic check_port(input string test, input int port, input line_addr_t line,
                            input int off, input int size, input data_t d);
    line_addr_t a_line;
    bank_t      a_bb;
    bank_t      a_be;
    ben_t       a_benb;
    ben_t       a_bene;
    data_t      a_data;
    int         last;
    if (port == 0) begin
      a_line = st0_line;
      a_bb = st0_bank_begin;
      a_be = st0_bank_end;
      a_benb = st0_ben_begin;
      a_bene = st0_ben_end;
      a_data = st0_data;
    end else begin
      a_line = st1_line;
      a_bb = st1_bank_begin;
      a_be = st1_bank_end;
      a_benb = st1_ben_begin;
      a_bene = st1_ben_end;
      a_data = st1_data;
    end
    last = off + (1 << size) - 1;
    check_value(test, $sformatf("st%0d_line", port), line, a_line);
    check_value(test, $sformatf("st%0d_bank_begin", port), off / 4, a_bb);
    check_value(test, $sformatf("st%0d_bank_end", port), last / 4, a_be);
    check_value(test, $sformatf("st%0d_ben_begin", port), model_ben_begin(off, size), a_benb);
    check_value(test, $sformatf("st%0d_ben_end", port), model_ben_end(off, size), a_bene);
    check_value(test, $sformatf("st%0d_data", port), model_rotate(d, off), a_data);
  endtask

  task automatic load_requests(input logic e0, input line_addr_t l0, input offset_t o0,
                               input size_t s0, input data_t d0,
                               input logic e1, input line_addr_t l1, input offset_t o1,
                               input size_t s1, input data_t d1);
    req0_en <= e0;
    req0_line <= l0;
    req0_offset <= o0;
    req0_size <= s0;
    req0_data <= d0;
    req1_en <= e1;
    req1_line <= l1;
    req1_offset <= o1;
    req1_size <= s1;
    req1_data <= d1;
  endtask

  task automatic clear_requests();
    req0_en <= 1'b0;
    req1_en <= 1'b0;
  endtask

  task automatic set_hold(input int which, input logic level);
    case (which)
      0: bus_hold <= level;
      1: miss_hold <= level;
      2: miss_pause <= level;
      default: insert_data <= level;
    endcase
  endtask

  // offers one pair without holds and checks both issue cycles
  task automatic run_pair(input string test,
                          input logic e0, input line_addr_t l0, input offset_t o0,
                          input size_t s0, input data_t d0,
                          input logic e1, input line_addr_t l1, input offset_t o1,
                          input size_t s1, input data_t d1);
    logic conf;
    conf = e0 && e1 && model_conflict(l0, o0, s0, l1, o1, s1);
    @(posedge clk);
    load_requests(e0, l0, o0, s0, d0, e1, l1, o1, s1, d1);
    @(posedge clk);
    // a split pair stays offered while busy and must not be taken again
    if (!conf)
      clear_requests();
    @(negedge clk);
    check_strobes(test, e0, e1 && !conf, conf);
    if (e0)
      check_port(test, 0, l0, o0, s0, d0);
    if (e1 && !conf)
      check_port(test, 1, l1, o1, s1, d1);
    if (conf) begin
      @(posedge clk);
      clear_requests();
      @(negedge clk);
      check_strobes(test, 1'b0, 1'b1, 1'b0);
      check_port(test, 1, l1, o1, s1, d1);
    end
  endtask

  task automatic check_reset();
    @(negedge clk);
    check_strobes("reset_state", 1'b0, 1'b0, 1'b0);
    finish_test("reset_state");
  endtask

  task automatic single_store();
    data_t d;
    d = 128'h00112233_44556677_8899aabb_ccddeeff;
    run_pair("single_store", 1'b1, 30'h10, 7'd0, 3'd0, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    run_pair("single_store", 1'b1, 30'h10, 7'd5, 3'd1, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    // bytes 2 to 5 span banks 0 and 1
    run_pair("single_store", 1'b1, 30'h11, 7'd2, 3'd2, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    run_pair("single_store", 1'b1, 30'h12, 7'd13, 3'd3, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    run_pair("single_store", 1'b1, 30'h13, 7'd112, 3'd4, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    run_pair("single_store", 1'b1, 30'h14, 7'd127, 3'd0, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    run_pair("single_store", 1'b1, 30'h15, 7'd62, 3'd2, d, 1'b0, 30'h0, 7'd0, 3'd0, '0);
    finish_test("single_store");
  endtask

  task automatic dual_no_conflict();
    data_t d0;
    data_t d1;
    d0 = 128'hfedcba98_76543210_01234567_89abcdef;
    d1 = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
    run_pair("dual_no_conflict", 1'b1, 30'h20, 7'd0, 3'd3, d0, 1'b1, 30'h20, 7'd8, 3'd3, d1);
    run_pair("dual_no_conflict", 1'b1, 30'h21, 7'd16, 3'd4, d0, 1'b1, 30'h22, 7'd16, 3'd4, d1);
    run_pair("dual_no_conflict", 1'b1, 30'h23, 7'd6, 3'd1, d0, 1'b1, 30'h23, 7'd3, 3'd1, d1);
    finish_test("dual_no_conflict");
  endtask

  task automatic dual_conflict();
    data_t d0;
    data_t d1;
    d0 = 128'h11111111_22222222_33333333_44444444;
    d1 = 128'h55555555_66666666_77777777_88888888;
    run_pair("dual_conflict", 1'b1, 30'h30, 7'd4, 3'd2, d0, 1'b1, 30'h30, 7'd6, 3'd1, d1);
    run_pair("dual_conflict", 1'b1, 30'h31, 7'd32, 3'd4, d0, 1'b1, 30'h31, 7'd40, 3'd3, d1);
    run_pair("dual_conflict", 1'b1, 30'h32, 7'd9, 3'd0, d0, 1'b1, 30'h32, 7'd9, 3'd0, d1);
    finish_test("dual_conflict");
  endtask

  task automatic hold_blocks();
    data_t d0;
    data_t d1;
    d0 = 128'hdeadbeef_01020304_05060708_090a0b0c;
    d1 = 128'hcafef00d_a1a2a3a4_b1b2b3b4_c1c2c3c4;
    for (int h = 0; h < 4; h++) begin
      @(posedge clk);
      set_hold(h, 1'b1);
      load_requests(1'b1, 30'h40 + h, 7'd8, 3'd2, d0, 1'b1, 30'h40 + h, 7'd40, 3'd3, d1);
      repeat (4) begin
        @(negedge clk);
        check_strobes("hold_blocks", 1'b0, 1'b0, 1'b0);
      end
      @(posedge clk);
      set_hold(h, 1'b0);
      @(negedge clk);
      check_strobes("hold_blocks", 1'b0, 1'b0, 1'b0);
      @(posedge clk);
      clear_requests();
      @(negedge clk);
      check_strobes("hold_blocks", 1'b1, 1'b1, 1'b0);
      check_port("hold_blocks", 0, 30'h40 + h, 8, 2, d0);
      check_port("hold_blocks", 1, 30'h40 + h, 40, 3, d1);
    end
    finish_test("hold_blocks");
  endtask

  task automatic hold_pending();
    data_t d0;
    data_t d1;
    d0 = 128'h0badc0de_0badc0de_0badc0de_0badc0de;
    d1 = 128'h13579bdf_2468ace0_13579bdf_2468ace0;
    for (int h = 0; h < 4; h++) begin
      @(posedge clk);
      load_requests(1'b1, 30'h50, 7'd20, 3'd3, d0, 1'b1, 30'h50, 7'd24, 3'd2, d1);
      @(posedge clk);
      clear_requests();
      set_hold(h, 1'b1);
      @(negedge clk);
      check_strobes("hold_pending", 1'b1, 1'b0, 1'b1);
      check_port("hold_pending", 0, 30'h50, 20, 3, d0);
      repeat (3) begin
        @(negedge clk);
        check_strobes("hold_pending", 1'b0, 1'b0, 1'b1);
      end
      @(posedge clk);
      set_hold(h, 1'b0);
      @(negedge clk);
      check_strobes("hold_pending", 1'b0, 1'b0, 1'b1);
      @(negedge clk);
      check_strobes("hold_pending", 1'b0, 1'b1, 1'b0);
      check_port("hold_pending", 1, 30'h50, 24, 2, d1);
    end
    finish_test("hold_pending");
  endtask

  // offset + bytes never runs past the line end
  task automatic random_store(output line_addr_t line, output offset_t off,
                              output size_t size, output data_t d);
    size = $unsigned($random(seed)) % 5;
    off = $unsigned($random(seed)) % (129 - (1 << size));
    // only two lines so that same-line pairs come up often
    line = 30'h155 + ($unsigned($random(seed)) % 2);
    d = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic random_pairs();
    line_addr_t l0;
    line_addr_t l1;
    offset_t    o0;
    offset_t    o1;
    size_t      s0;
    size_t      s1;
    data_t      d0;
    data_t      d1;
    logic [1:0] en;
    for (int n = 0; n < random_iters; n++) begin
      random_store(l0, o0, s0, d0);
      random_store(l1, o1, s1, d1);
      en = $random(seed);
      run_pair("random_pairs", en[0], l0, o0, s0, d0, en[1], l1, o1, s1, d1);
    end
    finish_test("random_pairs");
  endtask

  initial begin
    seed = 66778;
    checks = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst = 1'b1;
    bus_hold = 1'b0;
    miss_hold = 1'b0;
    miss_pause = 1'b0;
    insert_data = 1'b0;
    req0_en = 1'b0;
    req0_line = '0;
    req0_offset = '0;
    req0_size = '0;
    req0_data = '0;
    req1_en = 1'b0;
    req1_line = '0;
    req1_offset = '0;
    req1_size = '0;
    req1_data = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    check_reset();
    single_store();
    dual_no_conflict();
    dual_conflict();
    hold_blocks();
    hold_pending();
    random_pairs();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== design/store_issue_top.sv ====
// store_issue_top: two-port store issue path with conflict serialization
`timescale 1ns/1ps

module store_issue_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        bus_hold,
  input  logic                        miss_hold,
  input  logic                        miss_pause,
  input  logic                        insert_data,
  input  logic                        req0_en,
  input  store_issue_pkg::line_addr_t req0_line,
  input  store_issue_pkg::offset_t    req0_offset,
  input  store_issue_pkg::size_t      req0_size,
  input  store_issue_pkg::data_t      req0_data,
  input  logic                        req1_en,
  input  store_issue_pkg::line_addr_t req1_line,
  input  store_issue_pkg::offset_t    req1_offset,
  input  store_issue_pkg::size_t      req1_size,
  input  store_issue_pkg::data_t      req1_data,
  output logic                        busy,
  output logic                        st0_en,
  output store_issue_pkg::line_addr_t st0_line,
  output store_issue_pkg::bank_t      st0_bank_begin,
  output store_issue_pkg::bank_t      st0_bank_end,
  output store_issue_pkg::ben_t       st0_ben_begin,
  output store_issue_pkg::ben_t       st0_ben_end,
  output store_issue_pkg::data_t      st0_data,
  output logic                        st1_en,
  output store_issue_pkg::line_addr_t st1_line,
  output store_issue_pkg::bank_t      st1_bank_begin,
  output store_issue_pkg::bank_t      st1_bank_end,
  output store_issue_pkg::ben_t       st1_ben_begin,
  output store_issue_pkg::ben_t       st1_ben_end,
  output store_issue_pkg::data_t      st1_data
);

  logic conflict;
  logic load0;
  logic load1;

  store_overlap_check overlap (
    .req0_line   (req0_line),
    .req0_offset (req0_offset),
    .req0_size   (req0_size),
    .req1_line   (req1_line),
    .req1_offset (req1_offset),
    .req1_size   (req1_size),
    .conflict    (conflict)
  );

  store_issue_ctrl ctrl (
    .clk         (clk),
    .rst         (rst),
    .bus_hold    (bus_hold),
    .miss_hold   (miss_hold),
    .miss_pause  (miss_pause),
    .insert_data (insert_data),
    .req0_en     (req0_en),
    .req1_en     (req1_en),
    .conflict    (conflict),
    .load0       (load0),
    .load1       (load1),
    .st0_en      (st0_en),
    .st1_en      (st1_en),
    .busy        (busy)
  );

  store_lane lane0 (
    .clk        (clk),
    .rst        (rst),
    .load       (load0),
    .line_in    (req0_line),
    .offset_in  (req0_offset),
    .size_in    (req0_size),
    .data_in    (req0_data),
    .line       (st0_line),
    .bank_begin (st0_bank_begin),
    .bank_end   (st0_bank_end),
    .ben_begin  (st0_ben_begin),
    .ben_end    (st0_ben_end),
    .data       (st0_data)
  );

  // port 1 payload is captured with port 0 even when its issue is deferred
  store_lane lane1 (
    .clk        (clk),
    .rst        (rst),
    .load       (load1),
    .line_in    (req1_line),
    .offset_in  (req1_offset),
    .size_in    (req1_size),
    .data_in    (req1_data),
    .line       (st1_line),
    .bank_begin (st1_bank_begin),
    .bank_end   (st1_bank_end),
    .ben_begin  (st1_ben_begin),
    .ben_end    (st1_ben_end),
    .data       (st1_data)
  );

endmodule

// ==== design/store_issue_ctrl.sv ====
// store_issue_ctrl: acceptance, conflict serialization and issue strobes for two ports
`timescale 1ns/1ps

module store_issue_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic bus_hold,
  input  logic miss_hold,
  input  logic miss_pause,
  input  logic insert_data,
  input  logic req0_en,
  input  logic req1_en,
  input  logic conflict,
  output logic load0,
  output logic load1,
  output logic st0_en,
  output logic st1_en,
  output logic busy
);

  logic hold;
  logic accept;
  logic split;
  logic pending;

  // any hold blocks new issue and a pending port 1 store
  assign hold = bus_hold | miss_hold | miss_pause | insert_data;

  assign accept = !pending && !hold;
  assign load0 = accept && req0_en;
  assign load1 = accept && req1_en;

  // overlapping pair, port 1 waits one cycle behind port 0
  assign split = load0 && load1 && conflict;

  always_ff @(posedge clk) begin
    if (rst) begin
      st0_en <= 1'b0;
      st1_en <= 1'b0;
      pending <= 1'b0;
    end else begin
      st0_en <= load0;
      st1_en <= (load1 && !split) || (pending && !hold);
      // held pending store fires on the first cycle without a hold
      pending <= split || (pending && hold);
    end
  end

  assign busy = pending;

endmodule

// ==== design/store_lane.sv ====
// store_lane: registered payload of one issued store and its cache port fields
`timescale 1ns/1ps

module store_lane (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load,
  input  store_issue_pkg::line_addr_t line_in,
  input  store_issue_pkg::offset_t    offset_in,
  input  store_issue_pkg::size_t      size_in,
  input  store_issue_pkg::data_t      data_in,
  output store_issue_pkg::line_addr_t line,
  output store_issue_pkg::bank_t      bank_begin,
  output store_issue_pkg::bank_t      bank_end,
  output store_issue_pkg::ben_t       ben_begin,
  output store_issue_pkg::ben_t       ben_end,
  output store_issue_pkg::data_t      data
);
  import store_issue_pkg::*;

  offset_t offset_q;
  size_t   size_q;
  data_t   data_q;

  // payload stays put until the next load
  always_ff @(posedge clk) begin
    if (rst) begin
      line <= '0;
      offset_q <= '0;
      size_q <= '0;
      data_q <= '0;
    end else if (load) begin
      line <= line_in;
      offset_q <= offset_in;
      size_q <= size_in;
      data_q <= data_in;
    end
  end

  // port fields come from the held payload
  byte_enable_gen ben_gen (
    .offset     (offset_q),
    .size       (size_q),
    .bank_begin (bank_begin),
    .bank_end   (bank_end),
    .ben_begin  (ben_begin),
    .ben_end    (ben_end)
  );

  store_data_align data_align (
    .offset   (offset_q),
    .data_in  (data_q),
    .data_out (data)
  );

endmodule

// ==== design/store_data_align.sv ====
// store_data_align: byte rotation of store data into its lane position
`timescale 1ns/1ps

module store_data_align (
  input  store_issue_pkg::offset_t offset,
  input  store_issue_pkg::data_t   data_in,
  output store_issue_pkg::data_t   data_out
);
  import store_issue_pkg::*;

  localparam int lane_sel_w = $clog2(lane_bytes);

  logic [lane_sel_w-1:0] shift;

  // only the position inside the 16-byte lane matters
  assign shift = offset[lane_sel_w-1:0];

  always_comb begin
    logic [lane_sel_w-1:0] dst;
    data_out = '0;
    for (int i = 0; i < lane_bytes; i++) begin
      // wraps modulo the lane width
      dst = lane_sel_w'(i) + shift;
      data_out[dst*8 +: 8] = data_in[i*8 +: 8];
    end
  end

endmodule

// ==== design/byte_enable_gen.sv ====
// byte_enable_gen: begin/end bank and byte enables from store offset and size
`timescale 1ns/1ps

module byte_enable_gen (
  input  store_issue_pkg::offset_t offset,
  input  store_issue_pkg::size_t   size,
  output store_issue_pkg::bank_t   bank_begin,
  output store_issue_pkg::bank_t   bank_end,
  output store_issue_pkg::ben_t    ben_begin,
  output store_issue_pkg::ben_t    ben_end
);
  import store_issue_pkg::*;

  localparam int byte_sel_w = $clog2(bank_bytes);

  size_t                 size_c;
  offset_t               last;
  logic [byte_sel_w-1:0] first_byte;
  logic [byte_sel_w-1:0] last_byte;
  logic                  one_bank;

  // clamp illegal size codes to a full lane
  assign size_c = (size > size_t'(max_size_code)) ? size_t'(max_size_code) : size;

  // last byte touched, never past the line end
  assign last = offset + offset_t'((1 << size_c) - 1);

  assign bank_begin = bank_t'(offset >> byte_sel_w);
  assign bank_end = bank_t'(last >> byte_sel_w);
  assign first_byte = offset[byte_sel_w-1:0];
  assign last_byte = last[byte_sel_w-1:0];
  assign one_bank = (bank_begin == bank_end);

  always_comb begin
    for (int j = 0; j < bank_bytes; j++) begin
      // begin bank runs from the first byte upward
      ben_begin[j] = (j >= first_byte) && (!one_bank || (j <= last_byte));
      // end bank runs up to the last byte, both agree in the single bank case
      ben_end[j] = (j <= last_byte) && (!one_bank || (j >= first_byte));
    end
  end

endmodule

// ==== design/store_overlap_check.sv ====
// store_overlap_check: same-line byte overlap detection for two store requests
`timescale 1ns/1ps

module store_overlap_check (
  input  store_issue_pkg::line_addr_t req0_line,
  input  store_issue_pkg::offset_t    req0_offset,
  input  store_issue_pkg::size_t      req0_size,
  input  store_issue_pkg::line_addr_t req1_line,
  input  store_issue_pkg::offset_t    req1_offset,
  input  store_issue_pkg::size_t      req1_size,
  output logic                        conflict
);
  import store_issue_pkg::*;

  byte_mask_t mask0;
  byte_mask_t mask1;
  logic       same_line;
  logic       bytes_shared;

  // bytes touched by one store, offset up to offset + 2**size - 1
  function automatic byte_mask_t span_mask(offset_t offset, size_t size);
    size_t size_c;
    begin
      // oversized codes are treated as a full lane
      size_c = (size > size_t'(max_size_code)) ? size_t'(max_size_code) : size;
      span_mask = byte_mask_t'((1 << (1 << size_c)) - 1) << offset;
    end
  endfunction

  always_comb begin
    mask0 = span_mask(req0_offset, req0_size);
    mask1 = span_mask(req1_offset, req1_size);
  end

  assign same_line = (req0_line == req1_line);
  assign bytes_shared = |(mask0 & mask1);

  // enables are not looked at here, the controller qualifies them
  assign conflict = same_line && bytes_shared;

endmodule

// ==== design/store_issue_pkg.sv ====
// line geometry constants, field widths and shared types for the store issue path
package store_issue_pkg;

  // cache line geometry
  localparam int line_bytes = 128;
  localparam int bank_bytes = 4;
  localparam int bank_count = line_bytes / bank_bytes;

  // store data is one 16-byte lane
  localparam int lane_bytes = 16;

  // field widths
  localparam int line_addr_w = 30;
  localparam int offset_w = $clog2(line_bytes);
  localparam int bank_w = $clog2(bank_count);
  localparam int size_w = 3;

  // size code n means 2**n bytes, 16 bytes at most
  localparam int max_size_code = 4;

  // request fields
  typedef logic [line_addr_w-1:0] line_addr_t;
  typedef logic [offset_w-1:0] offset_t;
  typedef logic [size_w-1:0] size_t;

  // cache port fields
  typedef logic [bank_w-1:0] bank_t;
  typedef logic [bank_bytes-1:0] ben_t;
  typedef logic [lane_bytes*8-1:0] data_t;

  // one bit per byte of a line
  typedef logic [line_bytes-1:0] byte_mask_t;

endpackage
